// File: verilog/spiSlavePkg.sv
// SPI slave shared definitions
// Sequence states, command codes and header field positions

package spiSlavePkg;

	//------------------------------
	// Receive sequence
	//------------------------------
	// Header is two words, then data words until chip select rises
	typedef enum logic [1:0] {
		SeqAdrsGet = 2'd0,
		SeqCmdGet  = 2'd1,
		SeqDataGet = 2'd2
	} seqState_e;

	// Command codes carried in the second header word
	typedef enum logic [1:0] {
		CmdCsrRead  = 2'd0,
		CmdCsrWrite = 2'd1,
		CmdRamRead  = 2'd2,
		CmdRamWrite = 2'd3
	} spiCmd_e;

	//------------------------------
	// Widths
	//------------------------------
	localparam int WordBits  = 32;
	// Counts 0..31 falling edges per word
	localparam int CntWidth  = 5;
	// Pin synchronizer length
	localparam int SyncDepth = 3;

	// Second header word layout: cmd, length, dummy byte
	localparam int CmdMsb    = 25;
	localparam int CmdLsb    = 24;
	localparam int LenMsb    = 23;
	localparam int LenLsb    = 8;

	// Output widths
	localparam int AdrsWidth = 32;
	localparam int LenWidth  = 16;

endpackage

// File: verilog/spiSampler.sv
// SPI pin sampler
// Synchronizes SCK, MOSI and chip select to the system clock,
// finds SCK edges and collects MOSI bits into the receive word

`timescale 1ns/1ps

module spiSampler (
	input  logic                               iSysClk,
	input  logic                               rstN,
	input  logic                               spiSck,
	input  logic                               spiMosi,
	input  logic                               spiCsN,
	output logic                               sckRise,
	output logic                               sckFall,
	output logic                               csIdle,
	output logic [spiSlavePkg::WordBits-1:0]   rxWord
);

	// Stage 0 is the newest sample
	logic [spiSlavePkg::SyncDepth-1:0] sckSync;
	logic [spiSlavePkg::SyncDepth-1:0] mosiSync;
	logic [spiSlavePkg::SyncDepth-1:0] csSync;

	//------------------------------
	// Synchronizers
	//------------------------------
	// Chip select idles high, SCK idles low in mode 0
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sckSync <= '0;
			csSync  <= '1;
		end
		else
		begin
			sckSync <= {sckSync[spiSlavePkg::SyncDepth-2:0], spiSck};
			csSync  <= {csSync[spiSlavePkg::SyncDepth-2:0], spiCsN};
		end
	end

	// MOSI synchronizer
	always_ff @(posedge iSysClk)
	begin
		mosiSync <= {mosiSync[spiSlavePkg::SyncDepth-2:0], spiMosi};
	end

	//------------------------------
	// Edge detect
	//------------------------------
	// Pattern 011 is a rise, 100 a fall
	assign sckRise = !sckSync[2] && sckSync[1] && sckSync[0];
	assign sckFall = sckSync[2] && !sckSync[1] && !sckSync[0];

	// Oldest stage is the settled chip select
	assign csIdle  = csSync[spiSlavePkg::SyncDepth-1];

	// Receive word shifts in MSB first
	// MOSI taken from the stage where SCK just went high
	always_ff @(posedge iSysClk)
	begin
		if (sckRise)
			rxWord <= {rxWord[spiSlavePkg::WordBits-2:0], mosiSync[1]};
	end

	// Edges come from one vector and can never coincide
	edgeExclusive: assert property (@(posedge iSysClk) disable iff (!rstN)
		!(sckRise && sckFall));

endmodule

// File: verilog/spiBitCounter.sv
// SPI bit counter
// Counts SCK falling edges within a 32-bit word and flags the last one

`timescale 1ns/1ps

module spiBitCounter (
	input  logic iSysClk,
	input  logic rstN,
	input  logic sckFall,
	input  logic csIdle,
	output logic wordEnd
);

	// Last bit index of a word
	localparam logic [spiSlavePkg::CntWidth-1:0] LastBit =
		spiSlavePkg::CntWidth'(spiSlavePkg::WordBits - 1);

	logic [spiSlavePkg::CntWidth-1:0] bitCnt;

	// Falling edge count, wraps at 31
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			bitCnt <= '0;
		else if (csIdle)
			// Deselect drops any partial word
			bitCnt <= '0;
		else if (sckFall)
			bitCnt <= bitCnt + 1'b1;
	end

	// Pulse on the fall that completes bit 32
	assign wordEnd = sckFall && (bitCnt == LastBit);

endmodule

// File: verilog/spiSequenceFsm.sv
// SPI receive sequence FSM
// Walks address word, command word, then data words, and
// decodes the load and data strobes from state and word end

`timescale 1ns/1ps

module spiSequenceFsm (
	input  logic                   iSysClk,
	input  logic                   rstN,
	input  logic                   wordEnd,
	input  logic                   csIdle,
	output spiSlavePkg::seqState_e state,
	output logic                   adrsLoad,
	output logic                   hdrLoad,
	output logic                   dataWord
);

	spiSlavePkg::seqState_e stateNext;

	//------------------------------
	// Next state
	//------------------------------
	always_comb
	begin
		stateNext = state;
		if (csIdle)
			stateNext = spiSlavePkg::SeqAdrsGet;
		else if (wordEnd)
		begin
			case (state)
				spiSlavePkg::SeqAdrsGet: stateNext = spiSlavePkg::SeqCmdGet;
				spiSlavePkg::SeqCmdGet:  stateNext = spiSlavePkg::SeqDataGet;
				// Data phase runs until deselect
				default:                 stateNext = spiSlavePkg::SeqDataGet;
			endcase
		end
	end

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			state <= spiSlavePkg::SeqAdrsGet;
		else
			state <= stateNext;
	end

	//------------------------------
	// Strobes
	//------------------------------
	// One per completed word, chosen by phase
	assign adrsLoad = wordEnd && (state == spiSlavePkg::SeqAdrsGet);
	assign hdrLoad  = wordEnd && (state == spiSlavePkg::SeqCmdGet);
	assign dataWord = wordEnd && (state == spiSlavePkg::SeqDataGet);

	// Encoding 3 is never reached
	stateLegal: assert property (@(posedge iSysClk) disable iff (!rstN)
		state inside {spiSlavePkg::SeqAdrsGet, spiSlavePkg::SeqCmdGet,
			spiSlavePkg::SeqDataGet});

endmodule

// File: verilog/spiHeaderRegs.sv
// SPI header and data registers
// Captures address, command and length from the header words,
// presents each data word with a one-cycle valid and steps the address

`timescale 1ns/1ps

module spiHeaderRegs (
	input  logic                                iSysClk,
	input  logic                                rstN,
	input  logic                                adrsLoad,
	input  logic                                hdrLoad,
	input  logic                                dataWord,
	input  logic [spiSlavePkg::WordBits-1:0]    rxWord,
	output logic [spiSlavePkg::WordBits-1:0]    rdWord,
	output logic [spiSlavePkg::AdrsWidth-1:0]   adrs,
	output spiSlavePkg::spiCmd_e                cmd,
	output logic [spiSlavePkg::LenWidth-1:0]    dataLen,
	output logic                                rdValid
);

	//------------------------------
	// Header fields
	//------------------------------
	// Address from word 1, bumped once per delivered data word
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			adrs <= '0;
		else if (adrsLoad)
			adrs <= rxWord;
		else if (rdValid)
			// Step after the word has been seen with its address
			adrs <= adrs + 1'b1;
	end

	// Command and length from word 2, low byte is dummy
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cmd     <= spiSlavePkg::CmdCsrRead;
			dataLen <= '0;
		end
		else if (hdrLoad)
		begin
			cmd     <= spiSlavePkg::spiCmd_e'(rxWord[spiSlavePkg::CmdMsb:spiSlavePkg::CmdLsb]);
			dataLen <= rxWord[spiSlavePkg::LenMsb:spiSlavePkg::LenLsb];
		end
	end

	//------------------------------
	// Data words
	//------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rdValid <= 1'b0;
		else
			rdValid <= dataWord;
	end

	// Word held until the next one arrives
	always_ff @(posedge iSysClk)
	begin
		if (dataWord)
			rdWord <= rxWord;
	end

	// FSM decodes one phase per word end
	strobeOneHot: assert property (@(posedge iSysClk) disable iff (!rstN)
		$onehot0({adrsLoad, hdrLoad, dataWord}));

endmodule

// File: verilog/spiMisoShifter.sv
// SPI MISO shifter
// Loads the transmit word and sends it MSB first, one bit per SCK fall

`timescale 1ns/1ps

module spiMisoShifter (
	input  logic                              iSysClk,
	input  logic                              rstN,
	input  spiSlavePkg::seqState_e            state,
	input  logic                              wordEnd,
	input  logic                              sckFall,
	input  logic [spiSlavePkg::WordBits-1:0]  txWord,
	output logic                              spiMiso
);

	logic [spiSlavePkg::WordBits-1:0] txShift;

	// Idle line is high
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			txShift <= '1;
		else if (state != spiSlavePkg::SeqDataGet)
			// Track txWord during the header
			txShift <= txWord;
		else if (wordEnd)
			// Fresh word for the next data phase
			txShift <= txWord;
		else if (sckFall)
			// Next bit after master sampled on the rise
			txShift <= {txShift[spiSlavePkg::WordBits-2:0], 1'b1};
	end

	assign spiMiso = txShift[spiSlavePkg::WordBits-1];

endmodule

// File: verilog/spiSlaveTop.sv
// SPI slave top level for mode 0
// Receives an 8-byte header and 32-bit data words, drives MISO for reads

`timescale 1ns/1ps

module spiSlaveTop (
	input  logic                                iSysClk,
	input  logic                                rstN,
	// SPI pins
	input  logic                                spiSck,
	input  logic                                spiMosi,
	input  logic                                spiCsN,
	output logic                                spiMiso,
	// Inside
	input  logic [spiSlavePkg::WordBits-1:0]    txWord,
	output logic [spiSlavePkg::WordBits-1:0]    rdWord,
	output logic [spiSlavePkg::AdrsWidth-1:0]   adrs,
	output spiSlavePkg::spiCmd_e                cmd,
	output logic [spiSlavePkg::LenWidth-1:0]    dataLen,
	output logic                                rdValid
);

	logic                             sckRise;
	logic                             sckFall;
	logic                             csIdle;
	logic [spiSlavePkg::WordBits-1:0] rxWord;
	logic                             wordEnd;
	spiSlavePkg::seqState_e           state;
	logic                             adrsLoad;
	logic                             hdrLoad;
	logic                             dataWord;

	//------------------------------
	// Pin side
	//------------------------------
	spiSampler u_spiSampler (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCsN  (spiCsN),
		.sckRise (sckRise),
		.sckFall (sckFall),
		.csIdle  (csIdle),
		.rxWord  (rxWord)
	);

	spiBitCounter u_spiBitCounter (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.sckFall (sckFall),
		.csIdle  (csIdle),
		.wordEnd (wordEnd)
	);

	//------------------------------
	// Sequence and registers
	//------------------------------
	spiSequenceFsm u_spiSequenceFsm (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.wordEnd  (wordEnd),
		.csIdle   (csIdle),
		.state    (state),
		.adrsLoad (adrsLoad),
		.hdrLoad  (hdrLoad),
		.dataWord (dataWord)
	);

	spiHeaderRegs u_spiHeaderRegs (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.adrsLoad (adrsLoad),
		.hdrLoad  (hdrLoad),
		.dataWord (dataWord),
		.rxWord   (rxWord),
		.rdWord   (rdWord),
		.adrs     (adrs),
		.cmd      (cmd),
		.dataLen  (dataLen),
		.rdValid  (rdValid)
	);

	// Read data back to the master
	spiMisoShifter u_spiMisoShifter (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.state   (state),
		.wordEnd (wordEnd),
		.sckFall (sckFall),
		.txWord  (txWord),
		.spiMiso (spiMiso)
	);

endmodule

// File: dv/tbSpiSlave.sv
// SPI slave testbench
// Acts as a mode 0 master driven from the pattern file and checks the
// header fields, data words, address steps and MISO read data

`timescale 1ns/1ps

module tbSpiSlave;

	// Pattern record layout and master timing
	localparam int NumRecs   = 5;
	localparam int RecWords  = 10;
	localparam int HalfClks  = 6;
	localparam int PulseWait = 200;

	logic        iSysClk;
	logic        rstN;
	logic        spiSck;
	logic        spiMosi;
	logic        spiCsN;
	logic        spiMiso;
	logic [31:0] txWord;
	logic [31:0] rdWord;
	logic [31:0] adrs;
	logic [1:0]  cmd;
	logic [15:0] dataLen;
	logic        rdValid;

	logic [31:0] patMem [0:NumRecs*RecWords-1];

	// Captured at each rdValid pulse
	logic [31:0] wordQ[$];
	logic [31:0] adrsQ[$];
	logic [1:0]  cmdQ[$];
	logic [15:0] lenQ[$];

	integer seed;
	int     errCnt;
	int     checkCnt;
	int     testCnt;

	spiSlaveTop u_spiSlaveTop (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCsN  (spiCsN),
		.spiMiso (spiMiso),
		.txWord  (txWord),
		.rdWord  (rdWord),
		.adrs    (adrs),
		.cmd     (cmd),
		.dataLen (dataLen),
		.rdValid (rdValid)
	);

	// 40 ns system clock
	always #20 iSysClk = ~iSysClk;

	//------------------------------
	// Monitor
	//------------------------------
	// Falling edge, outputs settled mid cycle
	always @(negedge iSysClk)
	begin
		if (rdValid)
		begin
			wordQ.push_back(rdWord);
			adrsQ.push_back(adrs);
			cmdQ.push_back(cmd);
			lenQ.push_back(dataLen);
		end
	end

	// Inputs change just after the rising edge
	task automatic stepClock();
		@(posedge iSysClk);
		#2;
	endtask

	// One bit per SCK period, MOSI set while SCK low
	task automatic shiftWord(input logic [31:0] w, input int nBits,
		output logic [31:0] misoBits);
		misoBits = '0;
		for (int i = 0; i < nBits; i++)
		begin
			spiSck  = 1'b0;
			spiMosi = w[31-i];
			repeat (HalfClks) stepClock();
			// Sampled at the rise
			misoBits = {misoBits[30:0], spiMiso};
			spiSck   = 1'b1;
			repeat (HalfClks) stepClock();
		end
	endtask

	task automatic waitForPulses(input int target, input int testId);
		int waited;
		waited = 0;
		while (wordQ.size() < target && waited < PulseWait)
		begin
			stepClock();
			waited++;
		end
		if (wordQ.size() < target)
		begin
			$display("test %0d: no rdValid pulse %0d within %0d clocks", testId,
				wordQ.size(), PulseWait);
			errCnt++;
		end
	endtask

	// Idle outputs during and after reset
	task automatic checkIdle();
		checkCnt += 2;
		if (rdValid !== 1'b0)
		begin
			$display("** Error rdValid: got %h, expected %h", rdValid, 1'b0);
			errCnt++;
		end
		if (spiMiso !== 1'b1)
		begin
			$display("** Error spiMiso: got %h, expected %h", spiMiso, 1'b1);
			errCnt++;
		end
	endtask

	//------------------------------
	// One transaction
	//------------------------------
	task automatic runTransaction(input int rec);
		int          base;
		int          nWords;
		int          cutoff;
		int          nBits;
		int          gap;
		int          errStart;
		logic [31:0] expAdrs;
		logic [1:0]  expCmd;
		logic [15:0] expLen;
		logic [31:0] expTx;
		logic [31:0] hdrWord;
		logic [31:0] got;
		logic [31:0] expBits;
		logic [31:0] stepAdrs;
		logic [1:0]  gotCmd;
		logic [15:0] gotLen;

		base     = rec * RecWords;
		expAdrs  = patMem[base];
		expCmd   = patMem[base+1][1:0];
		expLen   = patMem[base+2][15:0];
		expTx    = patMem[base+3];
		nWords   = int'(patMem[base+4]);
		cutoff   = int'(patMem[base+5]);
		errStart = errCnt;
		// Spare bits, command, length, dummy byte
		hdrWord  = {6'b0, expCmd, expLen, 8'h00};

		wordQ.delete();
		adrsQ.delete();
		cmdQ.delete();
		lenQ.delete();
		txWord = expTx;
		spiCsN = 1'b0;
		repeat (HalfClks) stepClock();
		shiftWord(expAdrs, 32, got);
		shiftWord(hdrWord, 32, got);

		// Full words, then the cut-off word if any
		for (int k = 0; k <= nWords; k++)
		begin
			nBits = (k < nWords) ? 32 : cutoff;
			if (nBits != 0)
			begin
				shiftWord(patMem[base+6+k], nBits, got);
				expBits = expTx >> (32 - nBits);
				checkCnt++;
				if (got !== expBits)
				begin
					$display("** Error spiMiso word %0d: got %h, expected %h", k, got,
						expBits);
					errCnt++;
				end
			end
		end

		// Final fall completes the last bit
		spiSck = 1'b0;
		repeat (HalfClks) stepClock();
		spiCsN = 1'b1;
		waitForPulses(nWords, rec + 1);
		gap = 6 + ($random(seed) & 15);
		repeat (gap) stepClock();

		checkCnt++;
		if (wordQ.size() != nWords)
		begin
			$display("** Error rdValid count: got %h, expected %h", wordQ.size(), nWords);
			errCnt++;
		end
		for (int k = 0; k < nWords && k < wordQ.size(); k++)
		begin
			stepAdrs = expAdrs + 32'(k);
			checkCnt += 2;
			if (wordQ[k] !== patMem[base+6+k])
			begin
				$display("** Error rdWord %0d: got %h, expected %h", k, wordQ[k],
					patMem[base+6+k]);
				errCnt++;
			end
			if (adrsQ[k] !== stepAdrs)
			begin
				$display("** Error adrs %0d: got %h, expected %h", k, adrsQ[k], stepAdrs);
				errCnt++;
			end
		end

		// Header at the first pulse, or as held when no data came
		if (wordQ.size() > 0)
		begin
			gotCmd = cmdQ[0];
			gotLen = lenQ[0];
		end
		else
		begin
			gotCmd = cmd;
			gotLen = dataLen;
		end
		checkCnt += 2;
		if (gotCmd !== expCmd)
		begin
			$display("** Error cmd: got %h, expected %h", gotCmd, expCmd);
			errCnt++;
		end
		if (gotLen !== expLen)
		begin
			$display("** Error dataLen: got %h, expected %h", gotLen, expLen);
			errCnt++;
		end
		testCnt++;
		$display("test %0d: adrs %h, %0d words, cutoff %0d: %s", rec + 1, expAdrs, nWords,
			cutoff, (errCnt == errStart) ? "ok" : "failed");
	endtask

	initial
	begin
		iSysClk  = 1'b0;
		rstN     = 1'b0;
		spiSck   = 1'b0;
		spiMosi  = 1'b0;
		spiCsN   = 1'b1;
		// All ones keeps MISO high after reset
		txWord   = '1;
		seed     = 32'h719a_75b4;
		errCnt   = 0;
		checkCnt = 0;
		testCnt  = 0;
		$readmemh("dv/spiPatterns.txt", patMem);

		// Reset held 16 cycles
		repeat (16)
		begin
			stepClock();
			checkIdle();
		end
		rstN = 1'b1;
		repeat (4)
		begin
			stepClock();
			checkIdle();
		end
		testCnt++;
		$display("test 0: reset: %s", (errCnt == 0) ? "ok" : "failed");

		for (int r = 0; r < NumRecs; r++)
			runTransaction(r);

		$display("tests %0d, checks %0d, errors %0d", testCnt, checkCnt, errCnt);
		if (errCnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: dv/spiPatterns.txt
// address command length txWord words cutoff word0 word1 word2 word3
// All hex; cutoff is the bit count of an extra word cut short by chip select
00001000 00000003 00000010 a5a50f0f 00000004 00000000 12345678 9abcdef0 00000001 fffffffe
80000000 00000000 00000004 13579bdf 00000001 00000000 cafef00d 00000000 00000000 00000000
000000fe 00000002 00000008 80000001 00000002 0000000d 5555aaaa 0f1e2d3c 7e7e7e7e 00000000
ffffffff 00000001 0000ffff 00000000 00000003 00000000 00000001 00000002 00000003 00000000
00002000 00000002 00000000 deadbeef 00000000 00000000 00000000 00000000 00000000 00000000

// File: tb.f
verilog/spiSlavePkg.sv
verilog/spiSampler.sv
verilog/spiBitCounter.sv
verilog/spiSequenceFsm.sv
verilog/spiHeaderRegs.sv
verilog/spiMisoShifter.sv
verilog/spiSlaveTop.sv
dv/tbSpiSlave.sv

// File: Makefile
# Verilator build and run for the SPI slave testbench

VERILATOR ?= verilator
TOP       ?= tbSpiSlave
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
